// File: verilog/jsonUartPkg.sv
`default_nettype none

package jsonUartPkg;

    // Drive-state codes, 5 to 7 fall back to STOP
    localparam logic [2:0] STATE_LEFT  = 3'd0;   // Turn left
    localparam logic [2:0] STATE_RIGHT = 3'd1;   // Turn right
    localparam logic [2:0] STATE_FAST  = 3'd2;   // Straight, half speed
    localparam logic [2:0] STATE_SLOW  = 3'd3;   // Straight, quarter speed
    localparam logic [2:0] STATE_STOP  = 3'd4;   // Both wheels still

    // Message geometry
    localparam int MAX_LEN = 27;                  // Longest JSON line incl. newline
    localparam int IDX_W   = $clog2(MAX_LEN + 1); // Char index width
    localparam int LINE_W  = MAX_LEN * 8;         // Packed line width in bits

    // Line lengths in bytes, newline included
    localparam logic [IDX_W-1:0] LEN_LEFT  = IDX_W'(27);
    localparam logic [IDX_W-1:0] LEN_RIGHT = IDX_W'(27);
    localparam logic [IDX_W-1:0] LEN_FAST  = IDX_W'(24);
    localparam logic [IDX_W-1:0] LEN_SLOW  = IDX_W'(26);
    localparam logic [IDX_W-1:0] LEN_STOP  = IDX_W'(20);

    localparam logic [7:0] CHR_NEWLINE = 8'h0A;  // Line terminator

    // Serial timing, short bit period for simulation
    localparam int CLKS_PER_BIT = 8;              // 434 for 115200 baud at 50 MHz
    localparam int DATA_BITS    = 8;              // 8N1 payload
    localparam int FRAME_BITS   = DATA_BITS + 2;  // Start + data + stop
    localparam int FRAME_CLKS   = FRAME_BITS * CLKS_PER_BIT;
    localparam int CLK_CNT_W    = $clog2(CLKS_PER_BIT);
    localparam int BIT_CNT_W    = $clog2(FRAME_BITS);

    // Sequencer FSM encoding
    localparam logic [1:0] SEQ_IDLE  = 2'd0;  // Waiting for start edge
    localparam logic [1:0] SEQ_SEND  = 2'd1;  // Offering characters
    localparam logic [1:0] SEQ_DRAIN = 2'd2;  // Last frame still on the wire
    localparam logic [1:0] SEQ_DONE  = 2'd3;  // Holding done until start drops

endpackage

`default_nettype wire

// File: verilog/jsonCmdRom.sv
`timescale 1ns/1ns
`default_nettype none

module jsonCmdRom
    import jsonUartPkg::*;
(
    input  wire logic [2:0]       cmdState,  // Latched drive state
    input  wire logic [IDX_W-1:0] charIdx,   // Position in line, 0 = first char
    output logic      [7:0]       charByte,  // ASCII at that position
    output logic      [IDX_W-1:0] msgLen     // Bytes in selected line
);

    logic [LINE_W-1:0] line;  // Right-justified, last char in low byte
    logic [IDX_W-1:0]  pos;   // Byte offset from the low end

    // Line select, first character sits in the highest used byte
    always_comb begin
        case (cmdState)
            STATE_LEFT: begin
                line   = LINE_W'("{\"T\":1,\"L\":-0.25,\"R\":0.25}\n");
                msgLen = LEN_LEFT;
            end
            STATE_RIGHT: begin
                line   = LINE_W'("{\"T\":1,\"L\":0.25,\"R\":-0.25}\n");
                msgLen = LEN_RIGHT;
            end
            STATE_FAST: begin
                line   = LINE_W'("{\"T\":1,\"L\":0.5,\"R\":0.5}\n");
                msgLen = LEN_FAST;
            end
            STATE_SLOW: begin
                line   = LINE_W'("{\"T\":1,\"L\":0.25,\"R\":0.25}\n");
                msgLen = LEN_SLOW;
            end
            default: begin  // STOP and unused codes
                line   = LINE_W'("{\"T\":1,\"L\":0,\"R\":0}\n");
                msgLen = LEN_STOP;
            end
        endcase
    end

    assign pos = msgLen - IDX_W'(1) - charIdx;  // Wraps past end, masked below

    // Past the end of the line the newline repeats
    assign charByte = (charIdx < msgLen) ? line[{pos, 3'b000} +: 8] : CHR_NEWLINE;

endmodule

`default_nettype wire

// File: verilog/cmdSequencer.sv
`timescale 1ns/1ns
`default_nettype none

module cmdSequencer
    import jsonUartPkg::*;
(
    input  wire logic             clk,
    input  wire logic             rst,
    input  wire logic             start,       // Rising edge launches a message
    input  wire logic [2:0]       driveState,  // External command select
    output logic      [2:0]       cmdState,    // State seen by ROM
    output logic      [IDX_W-1:0] charIdx,     // ROM read position
    input  wire logic [7:0]       charByte,    // ROM data
    input  wire logic [IDX_W-1:0] msgLen,      // ROM line length
    output logic                  txValid,     // Byte offered to UART
    output logic      [7:0]       txData,
    input  wire logic             txReady,     // UART idle
    output logic                  busy,
    output logic                  done,
    output logic      [7:0]       ledByte      // Last byte handed over
);

    logic [1:0]       seqState;
    logic             startQ;        // Previous start level
    logic             startRise;
    logic [2:0]       latchedState;  // Frozen for the whole message
    logic             txFire;        // Handshake completes this cycle
    logic             lastChar;
    logic [IDX_W-1:0] expLen;        // Length the latched state implies

    assign startRise = start & ~startQ;
    assign txFire    = txValid & txReady;
    assign lastChar  = (charIdx == msgLen - IDX_W'(1));

    // ROM follows the live input while idle so the first byte is ready at launch
    assign cmdState = (seqState == SEQ_IDLE) ? driveState : latchedState;

    assign busy = (seqState == SEQ_SEND) || (seqState == SEQ_DRAIN);
    assign done = (seqState == SEQ_DONE);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            seqState     <= SEQ_IDLE;
            startQ       <= 1'b0;
            latchedState <= STATE_STOP;
            charIdx      <= '0;
            txValid      <= 1'b0;
            ledByte      <= 8'h00;
        end else begin
            startQ <= start;
            if (txFire) begin
                ledByte <= txData;  // Mirror on LEDs
            end
            case (seqState)
                SEQ_IDLE: begin
                    if (startRise) begin
                        latchedState <= driveState;
                        txValid      <= 1'b1;      // First char offered right away
                        txData       <= charByte;
                        seqState     <= SEQ_SEND;
                    end
                end
                SEQ_SEND: begin
                    if (txFire) begin
                        txValid <= 1'b0;
                        if (lastChar) begin
                            seqState <= SEQ_DRAIN;
                        end else begin
                            charIdx <= charIdx + IDX_W'(1);
                        end
                    end else if (!txValid && txReady) begin
                        txValid <= 1'b1;  // UART idle again so offer next char
                        txData  <= charByte;
                    end
                end
                SEQ_DRAIN: begin
                    if (txReady) begin  // Newline frame finished
                        seqState <= SEQ_DONE;
                        charIdx  <= '0;
                    end
                end
                default: begin  // SEQ_DONE
                    if (!start) begin
                        seqState <= SEQ_IDLE;
                    end
                end
            endcase
        end
    end

    // Length the ROM should report for the latched command
    always_comb begin
        case (latchedState)
            STATE_LEFT:  expLen = LEN_LEFT;
            STATE_RIGHT: expLen = LEN_RIGHT;
            STATE_FAST:  expLen = LEN_FAST;
            STATE_SLOW:  expLen = LEN_SLOW;
            default:     expLen = LEN_STOP;
        endcase
    end

    // Index stays inside the line and ROM length agrees with the command
    assert property (@(posedge clk) disable iff (rst)
        busy |-> (charIdx < msgLen) && (msgLen == expLen));

    // Offered byte held until the UART takes it
    assert property (@(posedge clk) disable iff (rst)
        txValid && !txReady |=> txValid && $stable(txData));

endmodule

`default_nettype wire

// File: verilog/uartTx.sv
`timescale 1ns/1ns
`default_nettype none

module uartTx
    import jsonUartPkg::*;
(
    input  wire logic       clk,
    input  wire logic       rst,
    input  wire logic       txValid,  // Byte offered
    input  wire logic [7:0] txData,
    output logic            txReady,  // High only when idle
    output logic            txd       // Serial line, idles high
);

    logic                 active;    // Frame on the wire
    logic [DATA_BITS:0]   shiftReg;  // Remaining data bits plus stop bit
    logic [BIT_CNT_W-1:0] bitCnt;    // 0 = start bit, FRAME_BITS-1 = stop
    logic [CLK_CNT_W-1:0] clkCnt;    // Cycles within current bit
    logic                 txdReg;
    logic                 txFire;
    logic                 bitEnd;
    logic                 lastBit;

    assign txReady = ~active;
    assign txd     = txdReg;
    assign txFire  = txValid & txReady;
    assign bitEnd  = (clkCnt == CLK_CNT_W'(CLKS_PER_BIT - 1));
    assign lastBit = (bitCnt == BIT_CNT_W'(FRAME_BITS - 1));

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            active <= 1'b0;
            txdReg <= 1'b1;  // Line idle
            bitCnt <= '0;
            clkCnt <= '0;
        end else if (txFire) begin
            active   <= 1'b1;
            txdReg   <= 1'b0;              // Start bit next cycle
            shiftReg <= {1'b1, txData};    // Stop bit above the data
            bitCnt   <= '0;
            clkCnt   <= '0;
        end else if (active) begin
            if (bitEnd) begin
                clkCnt <= '0;
                if (lastBit) begin
                    active <= 1'b0;  // Stop bit done, ready next cycle
                    txdReg <= 1'b1;
                end else begin
                    bitCnt   <= bitCnt + BIT_CNT_W'(1);
                    txdReg   <= shiftReg[0];                    // LSB first
                    shiftReg <= {1'b1, shiftReg[DATA_BITS:1]};
                end
            end else begin
                clkCnt <= clkCnt + CLK_CNT_W'(1);
            end
        end
    end

    // Idle line must sit at the mark level
    assert property (@(posedge clk) disable iff (rst)
        txReady |-> txd);

    // Ready returns exactly one full frame after the byte was taken
    assert property (@(posedge clk) disable iff (rst)
        $rose(txReady) |-> $past(txValid && txReady, FRAME_CLKS + 1));

endmodule

`default_nettype wire

// File: verilog/jsonUartTop.sv
`timescale 1ns/1ns
`default_nettype none

module jsonUartTop
    import jsonUartPkg::*;
(
    input  wire logic       clk,
    input  wire logic       rst,
    input  wire logic       start,       // Launch level
    input  wire logic [2:0] driveState,  // Command select
    output logic            txd,         // UART transmit line
    output logic            busy,
    output logic            done,
    output logic      [7:0] ledByte      // Last char sent
);

    logic [2:0]       cmdState;
    logic [IDX_W-1:0] charIdx;
    logic [7:0]       charByte;
    logic [IDX_W-1:0] msgLen;
    logic             txValid;
    logic [7:0]       txData;
    logic             txReady;

    jsonCmdRom cmdRom (              // Message text lookup
        .cmdState (cmdState),
        .charIdx  (charIdx),
        .charByte (charByte),
        .msgLen   (msgLen)
    );

    cmdSequencer sequencer (         // Walks the line into the UART
        .clk        (clk),
        .rst        (rst),
        .start      (start),
        .driveState (driveState),
        .cmdState   (cmdState),
        .charIdx    (charIdx),
        .charByte   (charByte),
        .msgLen     (msgLen),
        .txValid    (txValid),
        .txData     (txData),
        .txReady    (txReady),
        .busy       (busy),
        .done       (done),
        .ledByte    (ledByte)
    );

    uartTx serializer (              // 8N1 output stage
        .clk     (clk),
        .rst     (rst),
        .txValid (txValid),
        .txData  (txData),
        .txReady (txReady),
        .txd     (txd)
    );

endmodule

`default_nettype wire

// File: testbench/jsonUartTb.sv
`timescale 1ns/1ns
`default_nettype none

module jsonUartTb
    import jsonUartPkg::*;
();

    localparam int NUM_MSGS       = 7;  // Five states, code 6, mid-message change
    localparam int TIMEOUT_CYCLES = (NUM_MSGS + 2) * MAX_LEN * FRAME_CLKS;  // Two lines spare

    logic       clk = 1'b0;
    logic       rst;
    logic       start;
    logic [2:0] driveState;
    logic       txd;
    logic       busy;
    logic       done;
    logic [7:0] ledByte;

    logic [7:0] rxQ[$];            // Bytes decoded from txd
    int         errCount    = 0;
    int         testsRun    = 0;
    int         testsFailed = 0;
    int         cycleCount  = 0;
    int         seed        = 32'hccdd;

    jsonUartTop uut (
        .clk        (clk),
        .rst        (rst),
        .start      (start),
        .driveState (driveState),
        .txd        (txd),
        .busy       (busy),
        .done       (done),
        .ledByte    (ledByte)
    );

    always #2 clk = ~clk;  // 4 ns period

    always @(posedge clk) begin  // Hard stop for a stuck run
        cycleCount++;
        if (cycleCount >= TIMEOUT_CYCLES) begin
            $display("Timeout, run still going after %0d cycles", cycleCount);
            $display("Testbench failed");
            $finish;
        end
    end

    // Line idles at mark level outside a message
    assert property (@(posedge clk) disable iff (rst) !busy |-> txd)
        else begin
            errCount++;
            $display("ERROR: txd %h expected %h", $sampled(txd), 1'b1);
        end

    // busy only ends where done starts
    assert property (@(posedge clk) disable iff (rst) $fell(busy) |-> done)
        else begin
            errCount++;
            $display("busy dropped without done rising");
        end

    assert property (@(posedge clk) disable iff (rst) done && start |=> done)
        else begin
            errCount++;
            $display("ERROR: done %h expected %h", $sampled(done), 1'b1);
        end

    assert property (@(posedge clk) disable iff (rst) done && !start |=> !done)
        else begin
            errCount++;
            $display("ERROR: done %h expected %h", $sampled(done), 1'b0);
        end

    // Serial decoder, samples near mid-bit on falling clock
    initial begin : rxDecoder
        logic [7:0] rxByte;
        rxByte = 8'h00;
        wait (rst === 1'b0);
        forever begin
            @(negedge txd);                               // Start bit edge
            repeat (CLKS_PER_BIT / 2) @(negedge clk);
            assert (txd == 1'b0) else begin
                errCount++;
                $display("Start bit on txd too short");
            end
            for (int b = 0; b < DATA_BITS; b++) begin
                repeat (CLKS_PER_BIT) @(negedge clk);
                rxByte = {txd, rxByte[7:1]};              // LSB arrives first
            end
            repeat (CLKS_PER_BIT) @(negedge clk);         // Stop bit
            assert (txd == 1'b1) else begin
                errCount++;
                $display("Stop bit sampled low after byte %h", rxByte);
            end
            rxQ.push_back(rxByte);
        end
    end

    task automatic stepCycle();
        @(posedge clk);
        #1;  // Drive and sample off the edge
    endtask

    task automatic checkByte(input string name, input logic [7:0] got, input logic [7:0] exp);
        assert (got === exp) else begin
            errCount++;
            $display("ERROR: %s %h expected %h", name, got, exp);
        end
    endtask

    task automatic checkBit(input string name, input logic got, input logic exp);
        assert (got === exp) else begin
            errCount++;
            $display("ERROR: %s %h expected %h", name, got, exp);
        end
    endtask

    // Reference text per drive state
    function automatic string expectedLine(input logic [2:0] state);
        case (state)
            STATE_LEFT:  return "{\"T\":1,\"L\":-0.25,\"R\":0.25}\n";
            STATE_RIGHT: return "{\"T\":1,\"L\":0.25,\"R\":-0.25}\n";
            STATE_FAST:  return "{\"T\":1,\"L\":0.5,\"R\":0.5}\n";
            STATE_SLOW:  return "{\"T\":1,\"L\":0.25,\"R\":0.25}\n";
            default:     return "{\"T\":1,\"L\":0,\"R\":0}\n";  // STOP and codes 5 to 7
        endcase
    endfunction

    task automatic finishTest(input string name, input int errBefore);
        testsRun++;
        if (errCount == errBefore) begin
            $display("Test %0d %s: PASS", testsRun, name);
        end else begin
            testsFailed++;
            $display("Test %0d %s: FAIL", testsRun, name);
        end
    endtask

    // One full message, optionally disturbed part way through
    task automatic sendLine(input string name, input logic [2:0] state, input bit midChange);
        string      expText;
        int         errBefore;
        int         holdCycles;
        logic [7:0] got;
        expText    = expectedLine(state);
        errBefore  = errCount;
        rxQ.delete();
        driveState = state;
        start      = 1'b1;
        for (int n = 0; n < 3 && txd; n++) begin
            stepCycle();
        end
        assert (!txd) else begin
            errCount++;
            $display("No start bit within 3 cycles of launch");
        end
        if (midChange) begin
            holdCycles = 40 + ($unsigned($random(seed)) % 1500);  // Well inside the line
            repeat (holdCycles) begin
                checkBit("busy", busy, 1'b1);
                stepCycle();
            end
            driveState = (state == STATE_LEFT) ? STATE_RIGHT : STATE_LEFT;
            start      = 1'b0;  // Must not abort
        end
        while (!done) begin
            checkBit("busy", busy, 1'b1);
            stepCycle();
        end
        checkByte("rxCount", 8'(rxQ.size()), 8'(expText.len()));  // Last stop already seen
        for (int i = 0; i < expText.len(); i++) begin
            got = (i < rxQ.size()) ? rxQ[i] : 8'h00;
            checkByte($sformatf("rxByte[%0d]", i), got, expText[i]);
        end
        checkByte("ledByte", ledByte, 8'h0A);
        if (rxQ.size() > 0) begin
            checkByte("firstByte", rxQ[0], 8'h7B);
        end
        if (start) begin
            stepCycle();
            stepCycle();
            checkBit("done", done, 1'b1);  // Held with start
            start = 1'b0;
        end
        stepCycle();
        checkBit("done", done, 1'b0);
        checkBit("busy", busy, 1'b0);
        finishTest(name, errBefore);
    endtask

    initial begin : stimulus
        int errBefore;
        rst        = 1'b1;
        start      = 1'b0;
        driveState = STATE_STOP;
        repeat (16) @(posedge clk);
        #1;
        rst = 1'b0;

        errBefore = errCount;
        repeat (12) begin  // Quiet outputs before any launch
            checkBit("txd", txd, 1'b1);
            checkBit("busy", busy, 1'b0);
            checkBit("done", done, 1'b0);
            checkByte("ledByte", ledByte, 8'h00);
            stepCycle();
        end
        finishTest("reset idle", errBefore);

        sendLine("left line", STATE_LEFT, 1'b0);
        sendLine("right line", STATE_RIGHT, 1'b0);
        sendLine("fast line", STATE_FAST, 1'b0);
        sendLine("slow line", STATE_SLOW, 1'b0);
        sendLine("stop line", STATE_STOP, 1'b0);
        sendLine("code 6 as stop", 3'd6, 1'b0);
        sendLine("mid-message change", STATE_LEFT, 1'b1);

        $display("Tests run %0d, failed %0d, errors %0d", testsRun, testsFailed, errCount);
        if (errCount == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: jsonUart.f
verilog/jsonUartPkg.sv
verilog/jsonCmdRom.sv
verilog/cmdSequencer.sv
verilog/uartTx.sv
verilog/jsonUartTop.sv
testbench/jsonUartTb.sv

// File: Makefile
VERILATOR  = verilator
FLAGS      = --binary --timing --assert -j 0
LINT_FLAGS = --lint-only --timing --assert
TOP        = jsonUartTb
FILELIST   = jsonUart.f
BUILD_DIR  = obj_dir

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "Testbench passed"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)
